/* files.f */
+incdir+verilog
verilog/wb_bus_pkg.sv
verilog/sys_map_pkg.sv
verilog/wb_abrg.sv
verilog/wb_target_mux.sv
verilog/wb_mem_slave.sv
verilog/wb_io_regs.sv
verilog/abrg_top.sv
testbench/abrg_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module abrg_tb \
  -f files.f \
  -Mdir obj_dir -o abrg_sim

./obj_dir/abrg_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"

/* testbench/abrg_tb.sv */
`include "abrg_macros.svh"

module abrg_tb;

  localparam int WBM_PERIOD  = 40;
  localparam int WBS_HALF    = 15;
  localparam int DRIVE_DLY   = 2;
  localparam int WIN_W       = 4;
  localparam int WINDOW      = 1 << WIN_W;
  localparam int RAND_CYCLES = 400;
  localparam int ACK_LIMIT   = 200;
  // Fill, register reads, random cycles, readback
  localparam int TOTAL_CYCLES = WINDOW + 4 + RAND_CYCLES + WINDOW + 4;

  logic                   rst_i;
  logic                   wbs_clk_i;
  logic                   wbm_clk_i;
  wb_bus_pkg::wb_req_t    wbs_req_i;
  logic                   wbs_stb_i;
  logic                   wbs_cyc_i;
  logic [`ABRG_DAT_W-1:0] wbs_dat_o;
  logic                   wbs_ack_o;

  logic [15:0]            lfsr;
  logic                   busy;
  int                     errors;
  int                     checks;
  int                     issued;
  int                     acks;

  // Reference model state
  logic [`ABRG_DAT_W-1:0] mem_model [0:`MEM_DEPTH-1];
  logic [`ABRG_DAT_W-1:0] scratch_model [0:1];
  logic [`ABRG_DAT_W-1:0] count_model;

  abrg_top DUT (
    .rst_i     (rst_i),
    .wbs_clk_i (wbs_clk_i),
    .wbm_clk_i (wbm_clk_i),
    .wbs_req_i (wbs_req_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o)
  );

  // ####################################################################
  // Clocks and watchdog
  // ####################################################################

  initial begin
    wbm_clk_i = 1'b0;
    forever #(WBM_PERIOD / 2) wbm_clk_i = ~wbm_clk_i;
  end

  // Period 30, drifts against the system clock
  initial begin
    wbs_clk_i = 1'b0;
    forever #WBS_HALF wbs_clk_i = ~wbs_clk_i;
  end

  initial begin
    #(TOTAL_CYCLES * 60 * WBM_PERIOD + 20 * WBM_PERIOD);
    $display("Timeout: the bus cycles did not finish within the time limit");
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Done: errors found");
    $finish;
  end

  // Ack pulses, and none without an outstanding cycle
  always @(negedge wbs_clk_i) begin
    if (wbs_ack_o) begin
      acks++;
      if (!busy) begin
        errors++;
        $display("Acknowledge seen with no cycle outstanding at %0t", $time);
      end
    end
  end

  // ####################################################################
  // Helpers
  // ####################################################################

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] dat,
                                              input logic [1:0] sel);
    logic [15:0] v;
    v = old;
    if (sel[0]) begin
      v[7:0] = dat[7:0];
    end
    if (sel[1]) begin
      v[15:8] = dat[15:8];
    end
    return v;
  endfunction

  function automatic wb_bus_pkg::wb_req_t random_request();
    wb_bus_pkg::wb_req_t r;
    r = '0;
    r.we  = (take_bits(1) != 0);
    r.tga = (take_bits(2) == 0);
    r.adr[WIN_W-1:0] = WIN_W'(take_bits(WIN_W));
    // Some high bits set, aliasing onto the same words
    if (take_bits(3) == 0) begin
      r.adr[`ABRG_ADR_W-1:`MEM_ADR_W] =
        (`ABRG_ADR_W - `MEM_ADR_W)'(take_bits(`ABRG_ADR_W - `MEM_ADR_W));
    end
    r.sel = 2'(take_bits(2));
    r.dat = 16'(take_bits(16));
    return r;
  endfunction

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  // Applies one completed cycle, returns read data
  task automatic update_model(input wb_bus_pkg::wb_req_t req, output logic [15:0] expected);
    logic [`MEM_ADR_W-1:0] idx;
    sys_map_pkg::io_reg_e  reg_idx;
    idx      = req.adr[`MEM_ADR_W-1:0];
    reg_idx  = sys_map_pkg::io_reg_e'(req.adr[1:0]);
    expected = '0;
    if (sys_map_pkg::space_e'(req.tga) == sys_map_pkg::SPACE_MEM) begin
      if (req.we) begin
        mem_model[idx] = merge_bytes(mem_model[idx], req.dat, req.sel);
      end else begin
        expected = mem_model[idx];
      end
    end else if (req.we) begin
      count_model = count_model + 16'd1;
      if (reg_idx == sys_map_pkg::IO_SCRATCH0) begin
        scratch_model[0] = merge_bytes(scratch_model[0], req.dat, req.sel);
      end else if (reg_idx == sys_map_pkg::IO_SCRATCH1) begin
        scratch_model[1] = merge_bytes(scratch_model[1], req.dat, req.sel);
      end
    end else begin
      case (reg_idx)
        sys_map_pkg::IO_SCRATCH0: expected = scratch_model[0];
        sys_map_pkg::IO_SCRATCH1: expected = scratch_model[1];
        sys_map_pkg::IO_WR_COUNT: expected = count_model;
        default:                  expected = `IO_ID_VALUE;
      endcase
    end
  endtask

  // Called DRIVE_DLY after a wbs edge, returns at the same phase
  task automatic run_cycle(input wb_bus_pkg::wb_req_t req, input logic hold);
    logic [15:0] expected;
    int          waited;
    wbs_req_i = req;
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    busy      = 1'b1;
    issued++;
    waited = 0;
    do begin
      @(posedge wbs_clk_i);
      #DRIVE_DLY;
      waited++;
    end while (!wbs_ack_o && waited < ACK_LIMIT);
    if (!wbs_ack_o) begin
      errors++;
      $display("No acknowledge for request %0d after %0d cycles", issued, waited);
    end else begin
      update_model(req, expected);
      if (!req.we) begin
        check_value("wbs_dat_o", expected, wbs_dat_o);
      end
    end
    // Master samples the ack here
    @(posedge wbs_clk_i);
    #DRIVE_DLY;
    busy = 1'b0;
    check_value("wbs_ack_o", 16'h0, 16'(wbs_ack_o));
    if (!hold) begin
      wbs_stb_i = 1'b0;
      wbs_cyc_i = 1'b0;
      @(posedge wbs_clk_i);
      #DRIVE_DLY;
      check_value("wbs_ack_o", 16'h0, 16'(wbs_ack_o));
    end
  endtask

  // ####################################################################
  // Stimulus
  // ####################################################################

  initial begin
    wb_bus_pkg::wb_req_t req;
    logic                hold;
    rst_i     = 1'b1;
    wbs_req_i = '0;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    busy      = 1'b0;
    errors    = 0;
    checks    = 0;
    issued    = 0;
    acks      = 0;
    lfsr      = 16'd20512;
    count_model      = '0;
    scratch_model[0] = '0;
    scratch_model[1] = '0;
    repeat (10) @(posedge wbm_clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    repeat (3) @(posedge wbs_clk_i);
    #DRIVE_DLY;

    // Fill the memory window so every read is defined
    for (int i = 0; i < WINDOW; i++) begin
      req     = '0;
      req.adr = `ABRG_ADR_W'(i);
      req.dat = 16'(take_bits(16));
      req.sel = 2'b11;
      req.we  = 1'b1;
      run_cycle(req, (i % 2) == 1);
    end

    // I/O registers straight after reset
    for (int i = 0; i < 4; i++) begin
      req     = '0;
      req.adr = `ABRG_ADR_W'(i);
      req.tga = 1'b1;
      run_cycle(req, 1'b1);
    end

    for (int n = 0; n < RAND_CYCLES; n++) begin
      req  = random_request();
      hold = (take_bits(1) != 0);
      run_cycle(req, hold);
    end

    // Back-to-back readback of both spaces
    for (int i = 0; i < WINDOW + 4; i++) begin
      req     = '0;
      req.tga = (i >= WINDOW);
      req.adr = (i >= WINDOW) ? `ABRG_ADR_W'(i - WINDOW) : `ABRG_ADR_W'(i);
      run_cycle(req, i != WINDOW + 3);
    end

    repeat (5) @(posedge wbs_clk_i);
    check_value("ack count", 16'(issued), 16'(acks));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* verilog/abrg_macros.svh */
`ifndef ABRG_MACROS_SVH
`define ABRG_MACROS_SVH

// ####################################################################
// Bus widths
// ####################################################################

// Word address, byte address bits 19 to 1
`define ABRG_ADR_W 19
`define ABRG_DAT_W 16
`define ABRG_SEL_W 2

// ####################################################################
// Targets
// ####################################################################

// Low address bits used by the word memory, higher bits alias
`define MEM_ADR_W 10
`define MEM_DEPTH (1 << `MEM_ADR_W)

// Identity register contents
`define IO_ID_VALUE 16'hA5B7
// Wait cycles before the I/O block answers
`define IO_WAIT 2
`define IO_CNT_W 2

`endif

/* verilog/abrg_top.sv */
`include "abrg_macros.svh"

module abrg_top (
  input  logic                   rst_i,
  input  logic                   wbs_clk_i,
  input  logic                   wbm_clk_i,
  input  wb_bus_pkg::wb_req_t    wbs_req_i,
  input  logic                   wbs_stb_i,
  input  logic                   wbs_cyc_i,
  output logic [`ABRG_DAT_W-1:0] wbs_dat_o,
  output logic                   wbs_ack_o
);

  wb_bus_pkg::wb_req_t wbm_req;
  logic                wbm_stb;
  wb_bus_pkg::wb_rsp_t wbm_rsp;
  logic                mem_stb;
  logic                io_stb;
  wb_bus_pkg::wb_rsp_t mem_rsp;
  wb_bus_pkg::wb_rsp_t io_rsp;

  // Clock domain crossing
  wb_abrg u_abrg (
    .rst_i     (rst_i),
    .wbs_clk_i (wbs_clk_i),
    .wbs_req_i (wbs_req_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .wbm_clk_i (wbm_clk_i),
    .wbm_req_o (wbm_req),
    .wbm_stb_o (wbm_stb),
    .wbm_rsp_i (wbm_rsp)
  );

  wb_target_mux u_mux (
    .wbm_req_i (wbm_req),
    .wbm_stb_i (wbm_stb),
    .mem_rsp_i (mem_rsp),
    .io_rsp_i  (io_rsp),
    .mem_stb_o (mem_stb),
    .io_stb_o  (io_stb),
    .wbm_rsp_o (wbm_rsp)
  );

  // Both targets see the same request
  wb_mem_slave u_mem (
    .rst_i     (rst_i),
    .wbm_clk_i (wbm_clk_i),
    .req_i     (wbm_req),
    .stb_i     (mem_stb),
    .rsp_o     (mem_rsp)
  );

  wb_io_regs u_io (
    .rst_i     (rst_i),
    .wbm_clk_i (wbm_clk_i),
    .req_i     (wbm_req),
    .stb_i     (io_stb),
    .rsp_o     (io_rsp)
  );

endmodule

/* verilog/sys_map_pkg.sv */
package sys_map_pkg;

  // ####################################################################
  // System address map
  // ####################################################################

  // Address space, from the tag bit
  typedef enum logic {
    SPACE_MEM = 1'b0,
    SPACE_IO  = 1'b1
  } space_e;

  // I/O register index, low two address bits
  typedef enum logic [1:0] {
    IO_SCRATCH0 = 2'd0,
    IO_SCRATCH1 = 2'd1,
    IO_WR_COUNT = 2'd2,
    IO_ID       = 2'd3
  } io_reg_e;

  // I/O block FSM
  typedef enum logic [1:0] {
    IO_IDLE = 2'd0,
    IO_WAIT = 2'd1,
    IO_ACK  = 2'd2
  } io_state_e;

endpackage

/* verilog/wb_abrg.sv */
`include "abrg_macros.svh"

module wb_abrg (
  input  logic                   rst_i,
  // Slave side, processor clock
  input  logic                   wbs_clk_i,
  input  wb_bus_pkg::wb_req_t    wbs_req_i,
  input  logic                   wbs_stb_i,
  input  logic                   wbs_cyc_i,
  output logic [`ABRG_DAT_W-1:0] wbs_dat_o,
  output logic                   wbs_ack_o,
  // Master side, system clock
  input  logic                   wbm_clk_i,
  output wb_bus_pkg::wb_req_t    wbm_req_o,
  output logic                   wbm_stb_o,
  input  wb_bus_pkg::wb_rsp_t    wbm_rsp_i
);

  logic                   wbs_stb;
  logic                   new_cycle;
  logic                   stb_q;
  logic                   ack_q;
  logic                   req_tgl;
  logic                   ack_tgl;
  logic [2:0]             req_sync;
  logic [2:0]             ack_sync;
  wb_bus_pkg::wb_req_t    req_meta;
  logic [`ABRG_DAT_W-1:0] rd_dat;
  logic [`ABRG_DAT_W-1:0] dat_meta;

  // ####################################################################
  // wbs domain
  // ####################################################################

  assign wbs_stb = wbs_stb_i & wbs_cyc_i;

  // Rising strobe, or strobe still held after an acked cycle
  assign new_cycle = (~stb_q & wbs_stb) | (ack_q & ~wbs_ack_o & wbs_stb);

  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      stb_q   <= 1'b0;
      ack_q   <= 1'b0;
      req_tgl <= 1'b0;
    end else begin
      stb_q <= wbs_stb;
      ack_q <= wbs_ack_o;
      if (new_cycle) begin
        req_tgl <= ~req_tgl;
      end
    end
  end

  // Ack toggle back from the wbm side
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      ack_sync <= 3'b000;
    end else begin
      ack_sync <= {ack_sync[1:0], ack_tgl};
    end
  end

  assign wbs_ack_o = ack_sync[2] ^ ack_sync[1];

  // Read data crosses in step with the ack toggle
  always_ff @(posedge wbs_clk_i) begin
    dat_meta  <= rd_dat;
    wbs_dat_o <= dat_meta;
  end

  // ####################################################################
  // wbm domain
  // ####################################################################

  always_ff @(posedge wbm_clk_i) begin
    if (rst_i) begin
      req_sync  <= 3'b000;
      wbm_stb_o <= 1'b0;
      ack_tgl   <= 1'b0;
    end else begin
      req_sync <= {req_sync[1:0], req_tgl};
      // Strobe held until the target acks
      if (wbm_stb_o) begin
        wbm_stb_o <= ~wbm_rsp_i.ack;
      end else begin
        wbm_stb_o <= req_sync[2] ^ req_sync[1];
      end
      if (wbm_rsp_i.ack) begin
        ack_tgl <= ~ack_tgl;
      end
    end
  end

  // Fields are stable while the master waits for ack
  always_ff @(posedge wbm_clk_i) begin
    req_meta  <= wbs_req_i;
    wbm_req_o <= req_meta;
  end

  always_ff @(posedge wbm_clk_i) begin
    if (wbm_rsp_i.ack) begin
      rd_dat <= wbm_rsp_i.dat;
    end
  end

endmodule

/* verilog/wb_bus_pkg.sv */
`include "abrg_macros.svh"

package wb_bus_pkg;

  // ####################################################################
  // Wishbone request and response
  // ####################################################################

  // Request fields of one cycle, strobe travels separately
  typedef struct packed {
    logic [`ABRG_ADR_W-1:0] adr;
    logic [`ABRG_DAT_W-1:0] dat;
    logic [`ABRG_SEL_W-1:0] sel;
    logic                   tga;
    logic                   we;
  } wb_req_t;

  // Target answer
  typedef struct packed {
    logic [`ABRG_DAT_W-1:0] dat;
    logic                   ack;
  } wb_rsp_t;

endpackage

/* verilog/wb_io_regs.sv */
`include "abrg_macros.svh"

module wb_io_regs (
  input  logic                rst_i,
  input  logic                wbm_clk_i,
  input  wb_bus_pkg::wb_req_t req_i,
  input  logic                stb_i,
  output wb_bus_pkg::wb_rsp_t rsp_o
);

  sys_map_pkg::io_state_e state;
  sys_map_pkg::io_reg_e   reg_sel;
  logic [`IO_CNT_W-1:0]   wait_cnt;
  logic [`ABRG_DAT_W-1:0] scratch0;
  logic [`ABRG_DAT_W-1:0] scratch1;
  logic [`ABRG_DAT_W-1:0] wr_count;
  logic                   do_write;

  assign reg_sel  = sys_map_pkg::io_reg_e'(req_i.adr[1:0]);
  assign do_write = (state == sys_map_pkg::IO_ACK) & req_i.we;

  // ####################################################################
  // Access FSM
  // ####################################################################

  always_ff @(posedge wbm_clk_i) begin
    if (rst_i) begin
      state    <= sys_map_pkg::IO_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        sys_map_pkg::IO_IDLE: begin
          wait_cnt <= '0;
          if (stb_i) begin
            state <= sys_map_pkg::IO_WAIT;
          end
        end
        sys_map_pkg::IO_WAIT: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == `IO_CNT_W'(`IO_WAIT - 1)) begin
            state <= sys_map_pkg::IO_ACK;
          end
        end
        default: begin
          state <= sys_map_pkg::IO_IDLE;
        end
      endcase
    end
  end

  // Registers, written in the ack cycle
  always_ff @(posedge wbm_clk_i) begin
    if (rst_i) begin
      scratch0 <= '0;
      scratch1 <= '0;
      wr_count <= '0;
    end else if (do_write) begin
      wr_count <= wr_count + 1'b1;
      for (int i = 0; i < `ABRG_SEL_W; i++) begin
        if (req_i.sel[i] && reg_sel == sys_map_pkg::IO_SCRATCH0) begin
          scratch0[8*i +: 8] <= req_i.dat[8*i +: 8];
        end
        if (req_i.sel[i] && reg_sel == sys_map_pkg::IO_SCRATCH1) begin
          scratch1[8*i +: 8] <= req_i.dat[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    case (reg_sel)
      sys_map_pkg::IO_SCRATCH0: rsp_o.dat = scratch0;
      sys_map_pkg::IO_SCRATCH1: rsp_o.dat = scratch1;
      sys_map_pkg::IO_WR_COUNT: rsp_o.dat = wr_count;
      default:                  rsp_o.dat = `IO_ID_VALUE;
    endcase
  end

  assign rsp_o.ack = (state == sys_map_pkg::IO_ACK);

endmodule

/* verilog/wb_mem_slave.sv */
`include "abrg_macros.svh"

module wb_mem_slave (
  input  logic                rst_i,
  input  logic                wbm_clk_i,
  input  wb_bus_pkg::wb_req_t req_i,
  input  logic                stb_i,
  output wb_bus_pkg::wb_rsp_t rsp_o
);

  logic [`ABRG_DAT_W-1:0] mem [0:`MEM_DEPTH-1];
  logic [`MEM_ADR_W-1:0]  idx;
  logic [`ABRG_DAT_W-1:0] dat_q;
  logic                   ack_q;
  logic                   access;

  // Upper address bits alias
  assign idx = req_i.adr[`MEM_ADR_W-1:0];

  // One access per strobe period
  assign access = stb_i & ~ack_q;

  // ####################################################################
  // Acknowledge
  // ####################################################################

  always_ff @(posedge wbm_clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // ####################################################################
  // Storage
  // ####################################################################

  always_ff @(posedge wbm_clk_i) begin
    if (access) begin
      if (req_i.we) begin
        // Byte lanes
        for (int i = 0; i < `ABRG_SEL_W; i++) begin
          if (req_i.sel[i]) begin
            mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
          end
        end
      end
      // Whole word, selects ignored on read
      dat_q <= mem[idx];
    end
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;

endmodule

/* verilog/wb_target_mux.sv */
module wb_target_mux (
  input  wb_bus_pkg::wb_req_t wbm_req_i,
  input  logic                wbm_stb_i,
  input  wb_bus_pkg::wb_rsp_t mem_rsp_i,
  input  wb_bus_pkg::wb_rsp_t io_rsp_i,
  output logic                mem_stb_o,
  output logic                io_stb_o,
  output wb_bus_pkg::wb_rsp_t wbm_rsp_o
);

  sys_map_pkg::space_e space;

  assign space = sys_map_pkg::space_e'(wbm_req_i.tga);

  // ####################################################################
  // Strobe steering
  // ####################################################################

  always_comb begin
    mem_stb_o = 1'b0;
    io_stb_o  = 1'b0;
    case (space)
      sys_map_pkg::SPACE_MEM: begin
        mem_stb_o = wbm_stb_i;
      end
      sys_map_pkg::SPACE_IO: begin
        io_stb_o = wbm_stb_i;
      end
      default: begin
        mem_stb_o = 1'b0;
        io_stb_o  = 1'b0;
      end
    endcase
  end

  // ####################################################################
  // Response select
  // ####################################################################

  // Ack of the other space is ignored
  always_comb begin
    case (space)
      sys_map_pkg::SPACE_IO: begin
        wbm_rsp_o.dat = io_rsp_i.dat;
        wbm_rsp_o.ack = io_rsp_i.ack;
      end
      default: begin
        wbm_rsp_o.dat = mem_rsp_i.dat;
        wbm_rsp_o.ack = mem_rsp_i.ack;
      end
    endcase
  end

endmodule
